/* source/link_defines.svh */
`ifndef LINK_DEFINES_SVH
`define LINK_DEFINES_SVH

// start state restored by reset and init
`define LINK_START_X 9'd1
`define LINK_START_Y 8'd96
`define LINK_START_HP 3'd6

// invincibility after a hit, counted in movement ticks
`define LINK_INVINCIBLE_TICKS 3'd7

// apply strobes per movement tick is 2 to this power
`define LINK_MOVE_DIVIDE_BITS 4

// walking sprite edge and sheet row length, in pixels
`define LINK_SPRITE_SIZE 16
`define LINK_SHEET_WIDTH 64

// sprite pixels of this colour are not written
`define LINK_TRANSPARENT 6'h3f

`endif

/* source/linkPkg.sv */
`default_nettype none

package linkPkg;

	// screen coordinates
	typedef logic [8:0] xPos_t;
	typedef logic [7:0] yPos_t;

	typedef logic [5:0] colour_t;

	// sheet address, row * 64 + column
	typedef logic [11:0] spriteAddr_t;

	typedef logic [2:0] hp_t;

	// latched walking command
	typedef enum logic [2:0] {
		actionNone,
		actionUp,
		actionDown,
		actionLeft,
		actionRight
	} action_t;

	typedef enum logic [1:0] {
		facingUp,
		facingDown,
		facingLeft,
		facingRight
	} facing_t;

endpackage

`default_nettype wire

/* source/linkMovement.sv */
`timescale 1ns/100ps
`default_nettype none

`include "link_defines.svh"

module linkMovement (
	input wire clock,
	input wire reset,
	input wire init,
	input wire regAction,
	input wire applyAction,
	input wire up,
	input wire down,
	input wire left,
	input wire right,
	input wire blocked,
	output linkPkg::xPos_t xPos,
	output linkPkg::yPos_t yPos,
	output linkPkg::facing_t facing,
	output logic moveTick
);

	linkPkg::action_t action;
	logic [`LINK_MOVE_DIVIDE_BITS-1:0] divider;
	logic tickNow;

	// only the apply strobe that finds the divider at zero moves the character
	assign tickNow = applyAction && (divider == '0);

	always_ff @(posedge clock) begin
		if (reset || init) begin
			action <= linkPkg::actionNone;
			divider <= '0;
			moveTick <= 1'b0;
			xPos <= `LINK_START_X;
			yPos <= `LINK_START_Y;
			facing <= linkPkg::facingDown;
		end else begin
			moveTick <= tickNow;

			// button priority is up, down, left, right
			if (regAction) begin
				if (up)
					action <= linkPkg::actionUp;
				else if (down)
					action <= linkPkg::actionDown;
				else if (left)
					action <= linkPkg::actionLeft;
				else if (right)
					action <= linkPkg::actionRight;
				else
					action <= linkPkg::actionNone;
			end

			if (applyAction)
				divider <= divider + 1'b1;

			// facing turns even when a wall holds the position
			if (tickNow) begin
				case (action)
					linkPkg::actionUp: begin
						facing <= linkPkg::facingUp;
						if (!blocked)
							yPos <= yPos - 1'b1;
					end
					linkPkg::actionDown: begin
						facing <= linkPkg::facingDown;
						if (!blocked)
							yPos <= yPos + 1'b1;
					end
					linkPkg::actionLeft: begin
						facing <= linkPkg::facingLeft;
						if (!blocked)
							xPos <= xPos - 1'b1;
					end
					linkPkg::actionRight: begin
						facing <= linkPkg::facingRight;
						if (!blocked)
							xPos <= xPos + 1'b1;
					end
					default: begin
						// standing still keeps facing and position
					end
				endcase
			end
		end
	end

endmodule

`default_nettype wire

/* source/linkHealth.sv */
`timescale 1ns/100ps
`default_nettype none

`include "link_defines.svh"

module linkHealth (
	input wire clock,
	input wire reset,
	input wire init,
	input wire hit,
	input wire moveTick,
	output linkPkg::hp_t hp,
	output logic invincible
);

	// movement ticks left before the next hit counts
	logic [2:0] countdown;

	always_ff @(posedge clock) begin
		if (reset || init) begin
			hp <= `LINK_START_HP;
			countdown <= '0;
		end else if (hit && (countdown == '0)) begin
			// hp saturates at zero
			if (hp != '0)
				hp <= hp - 1'b1;
			countdown <= `LINK_INVINCIBLE_TICKS;
		end else if (moveTick && (countdown != '0)) begin
			countdown <= countdown - 1'b1;
		end
	end

	assign invincible = (countdown != '0);

endmodule

`default_nettype wire

/* source/spriteScanner.sv */
`timescale 1ns/100ps
`default_nettype none

`include "link_defines.svh"

module spriteScanner (
	input wire clock,
	input wire reset,
	input wire draw,
	input wire linkPkg::xPos_t xPos,
	input wire linkPkg::yPos_t yPos,
	input wire linkPkg::facing_t facing,
	input wire invincible,
	input wire linkPkg::colour_t colour,
	output linkPkg::spriteAddr_t spriteAddress,
	output logic pixelWrite,
	output linkPkg::xPos_t pixelX,
	output linkPkg::yPos_t pixelY,
	output linkPkg::colour_t pixelColour,
	output logic drawDone
);

	// low nibble is the sprite column, high nibble the sprite row
	logic [7:0] count;
	logic finished;
	logic scanning;

	logic [5:0] baseCol;
	logic [5:0] baseRow;
	logic [5:0] sheetCol;
	logic [5:0] sheetRow;
	linkPkg::spriteAddr_t nextAddress;

	// first stage travels with the address, second with the colour
	logic issueValid;
	logic issueLast;
	linkPkg::xPos_t issueX;
	linkPkg::yPos_t issueY;
	logic slotValid;

	assign scanning = draw && !finished;

	// sheet columns hold down, left, up, right
	always_comb begin
		case (facing)
			linkPkg::facingDown: baseCol = 6'd0;
			linkPkg::facingLeft: baseCol = 6'(`LINK_SPRITE_SIZE);
			linkPkg::facingUp: baseCol = 6'(2 * `LINK_SPRITE_SIZE);
			default: baseCol = 6'(3 * `LINK_SPRITE_SIZE);
		endcase
	end

	// flashing sprites live in the bottom row of the sheet
	assign baseRow = invincible ? 6'(3 * `LINK_SPRITE_SIZE) : 6'd0;

	assign sheetCol = baseCol + {2'd0, count[3:0]};
	assign sheetRow = baseRow + {2'd0, count[7:4]};
	assign nextAddress = linkPkg::spriteAddr_t'(32'(sheetRow) * `LINK_SHEET_WIDTH
		+ 32'(sheetCol));

	always_ff @(posedge clock) begin
		if (reset) begin
			count <= '0;
			finished <= 1'b0;
			issueValid <= 1'b0;
			issueLast <= 1'b0;
			slotValid <= 1'b0;
			drawDone <= 1'b0;
		end else begin
			issueValid <= scanning;
			issueLast <= scanning && (count == 8'hff);
			slotValid <= issueValid;
			drawDone <= issueLast;

			// hold off after the last pixel until draw drops
			if (!draw) begin
				count <= '0;
				finished <= 1'b0;
			end else if (scanning) begin
				count <= count + 1'b1;
				if (count == 8'hff)
					finished <= 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (scanning) begin
			spriteAddress <= nextAddress;
			issueX <= xPos + {5'd0, count[3:0]};
			issueY <= yPos + {4'd0, count[7:4]};
		end
		// colour comes back one cycle after the address
		if (issueValid) begin
			pixelX <= issueX;
			pixelY <= issueY;
		end
	end

	assign pixelWrite = slotValid && (colour != `LINK_TRANSPARENT);
	assign pixelColour = colour;

endmodule

`default_nettype wire

/* source/linkCharacter.sv */
`timescale 1ns/100ps
`default_nettype none

module linkCharacter (
	input wire clock,
	input wire reset,
	input wire init,
	input wire regAction,
	input wire applyAction,
	input wire draw,
	input wire up,
	input wire down,
	input wire left,
	input wire right,
	input wire blocked,
	input wire hit,
	input wire linkPkg::colour_t colour,
	output wire linkPkg::xPos_t xPos,
	output wire linkPkg::yPos_t yPos,
	output wire linkPkg::facing_t facing,
	output wire linkPkg::hp_t hp,
	output wire linkPkg::spriteAddr_t spriteAddress,
	output wire pixelWrite,
	output wire linkPkg::xPos_t pixelX,
	output wire linkPkg::yPos_t pixelY,
	output wire linkPkg::colour_t pixelColour,
	output wire drawDone
);

	wire moveTick;
	wire invincible;

	linkMovement movement (
		.clock(clock),
		.reset(reset),
		.init(init),
		.regAction(regAction),
		.applyAction(applyAction),
		.up(up),
		.down(down),
		.left(left),
		.right(right),
		.blocked(blocked),
		.xPos(xPos),
		.yPos(yPos),
		.facing(facing),
		.moveTick(moveTick)
	);

	// invincibility runs down on movement ticks
	linkHealth health (
		.clock(clock),
		.reset(reset),
		.init(init),
		.hit(hit),
		.moveTick(moveTick),
		.hp(hp),
		.invincible(invincible)
	);

	spriteScanner scanner (
		.clock(clock),
		.reset(reset),
		.draw(draw),
		.xPos(xPos),
		.yPos(yPos),
		.facing(facing),
		.invincible(invincible),
		.colour(colour),
		.spriteAddress(spriteAddress),
		.pixelWrite(pixelWrite),
		.pixelX(pixelX),
		.pixelY(pixelY),
		.pixelColour(pixelColour),
		.drawDone(drawDone)
	);

endmodule

`default_nettype wire

/* sim/linkCharacterTb.sv */
`timescale 1ns/100ps
`default_nettype none

`include "link_defines.svh"

module linkCharacterTb;

	logic clock;
	logic reset;
	logic init;
	logic regAction;
	logic applyAction;
	logic draw;
	logic up;
	logic down;
	logic left;
	logic right;
	logic blocked;
	logic hit;
	linkPkg::colour_t colour = '0;

	wire linkPkg::xPos_t xPos;
	wire linkPkg::yPos_t yPos;
	wire linkPkg::facing_t facing;
	wire linkPkg::hp_t hp;
	wire linkPkg::spriteAddr_t spriteAddress;
	wire pixelWrite;
	wire linkPkg::xPos_t pixelX;
	wire linkPkg::yPos_t pixelY;
	wire linkPkg::colour_t pixelColour;
	wire drawDone;

	logic [31:0] lfsr;
	string testName;

	// reference model state
	linkPkg::action_t mAction;
	logic [`LINK_MOVE_DIVIDE_BITS-1:0] mDivider;
	linkPkg::xPos_t mX;
	linkPkg::yPos_t mY;
	linkPkg::facing_t mFacing;
	linkPkg::hp_t mHp;
	int mCountdown;
	logic mTickPending;

	linkCharacter dut (
		.clock(clock),
		.reset(reset),
		.init(init),
		.regAction(regAction),
		.applyAction(applyAction),
		.draw(draw),
		.up(up),
		.down(down),
		.left(left),
		.right(right),
		.blocked(blocked),
		.hit(hit),
		.colour(colour),
		.xPos(xPos),
		.yPos(yPos),
		.facing(facing),
		.hp(hp),
		.spriteAddress(spriteAddress),
		.pixelWrite(pixelWrite),
		.pixelX(pixelX),
		.pixelY(pixelY),
		.pixelColour(pixelColour),
		.drawDone(drawDone)
	);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	// sheet contents, some addresses come out all ones and stay transparent
	function automatic linkPkg::colour_t sheetColour(input linkPkg::spriteAddr_t address);
		return address[5:0] ^ address[11:6];
	endfunction

	// sprite memory with one cycle read latency
	always @(posedge clock)
		colour <= sheetColour(spriteAddress);

	function automatic logic [31:0] lfsrStep(input logic [31:0] state);
		logic [31:0] next;
		next = state >> 1;
		if (state[0])
			next = next ^ 32'h80200003;
		return next;
	endfunction

	task automatic randomBits(input int count, output logic [31:0] value);
		value = '0;
		for (int i = 0; i < count; i++) begin
			value = {value[30:0], lfsr[0]};
			lfsr = lfsrStep(lfsr);
		end
	endtask

	task automatic check(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected) begin
			$display("FAILED %s: expected %0d, actual %0d", name, expected, actual);
			$display("Test failed");
			$fatal(1, "value mismatch in %s", name);
		end
	endtask

	task automatic modelStart();
		mAction = linkPkg::actionNone;
		mDivider = '0;
		mX = `LINK_START_X;
		mY = `LINK_START_Y;
		mFacing = linkPkg::facingDown;
		mHp = `LINK_START_HP;
		mCountdown = 0;
		mTickPending = 1'b0;
	endtask

	// one rising edge of the model, using the inputs driven for this cycle
	task automatic modelClock();
		logic tickNow;
		tickNow = applyAction && (mDivider == '0);
		if (init) begin
			modelStart();
		end else begin
			if (hit && (mCountdown == 0)) begin
				if (mHp != 3'd0)
					mHp = mHp - 3'd1;
				mCountdown = `LINK_INVINCIBLE_TICKS;
			end else if (mTickPending && (mCountdown != 0)) begin
				mCountdown = mCountdown - 1;
			end
			if (tickNow) begin
				case (mAction)
					linkPkg::actionUp: begin
						mFacing = linkPkg::facingUp;
						if (!blocked)
							mY = mY - 8'd1;
					end
					linkPkg::actionDown: begin
						mFacing = linkPkg::facingDown;
						if (!blocked)
							mY = mY + 8'd1;
					end
					linkPkg::actionLeft: begin
						mFacing = linkPkg::facingLeft;
						if (!blocked)
							mX = mX - 9'd1;
					end
					linkPkg::actionRight: begin
						mFacing = linkPkg::facingRight;
						if (!blocked)
							mX = mX + 9'd1;
					end
					default: begin
					end
				endcase
			end
			if (regAction) begin
				if (up)
					mAction = linkPkg::actionUp;
				else if (down)
					mAction = linkPkg::actionDown;
				else if (left)
					mAction = linkPkg::actionLeft;
				else if (right)
					mAction = linkPkg::actionRight;
				else
					mAction = linkPkg::actionNone;
			end
			if (applyAction)
				mDivider = mDivider + 1'b1;
			mTickPending = tickNow;
		end
	endtask

	// outputs are sampled on the falling edge, where they are stable
	task automatic clockCycle();
		@(negedge clock);
		modelClock();
		check({testName, " xPos"}, mX, xPos);
		check({testName, " yPos"}, mY, yPos);
		check({testName, " facing"}, mFacing, facing);
		check({testName, " hp"}, mHp, hp);
	endtask

	task automatic randomActivity(input int rounds, input bit withHits);
		logic [31:0] bits;
		int burst;
		for (int r = 0; r < rounds; r++) begin
			randomBits(4, bits);
			{up, down, left, right} = bits[3:0];
			regAction = 1'b1;
			clockCycle();
			regAction = 1'b0;
			randomBits(6, bits);
			burst = int'(bits[5:0]) + 1;
			for (int i = 0; i < burst; i++) begin
				applyAction = 1'b1;
				randomBits(1, bits);
				blocked = bits[0];
				randomBits(3, bits);
				hit = withHits && (bits[2:0] == 3'd0);
				clockCycle();
			end
			applyAction = 1'b0;
			blocked = 1'b0;
			hit = 1'b0;
			clockCycle();
		end
	endtask

	task automatic drawSprite();
		linkPkg::xPos_t expX[$];
		linkPkg::yPos_t expY[$];
		linkPkg::colour_t expColour[$];
		linkPkg::spriteAddr_t expAddress[$];
		linkPkg::spriteAddr_t address;
		int baseCol;
		int baseRow;
		int expected;
		int writes;
		int cycles;
		// an idle cycle lets a pending movement tick reach the countdown
		clockCycle();
		case (mFacing)
			linkPkg::facingDown: baseCol = 0;
			linkPkg::facingLeft: baseCol = `LINK_SPRITE_SIZE;
			linkPkg::facingUp: baseCol = 2 * `LINK_SPRITE_SIZE;
			default: baseCol = 3 * `LINK_SPRITE_SIZE;
		endcase
		baseRow = (mCountdown != 0) ? 3 * `LINK_SPRITE_SIZE : 0;
		for (int k = 0; k < 256; k++) begin
			address = 12'((baseRow + k / 16) * `LINK_SHEET_WIDTH + baseCol + k % 16);
			expAddress.push_back(address);
			if (sheetColour(address) != `LINK_TRANSPARENT) begin
				expX.push_back(mX + 9'(k % 16));
				expY.push_back(mY + 8'(k / 16));
				expColour.push_back(sheetColour(address));
			end
		end
		expected = expX.size();
		writes = 0;
		cycles = 0;
		draw = 1'b1;
		do begin
			clockCycle();
			cycles++;
			// one new sheet address per cycle, starting the cycle after draw
			if (expAddress.size() != 0)
				check({testName, " spriteAddress"}, expAddress.pop_front(), spriteAddress);
			if (pixelWrite) begin
				writes++;
				if (expX.size() != 0) begin
					check({testName, " pixelX"}, expX.pop_front(), pixelX);
					check({testName, " pixelY"}, expY.pop_front(), pixelY);
					check({testName, " pixelColour"}, expColour.pop_front(), pixelColour);
				end
			end
		end while (!drawDone && (cycles < 300));
		if (!drawDone) begin
			$display("drawDone never arrived within 300 cycles of draw");
			$display("Test failed");
			$fatal(1, "draw timeout");
		end else begin
			check({testName, " drawDone cycle"}, 257, cycles);
			check({testName, " write count"}, expected, writes);
			draw = 1'b0;
			clockCycle();
			check({testName, " single drawDone"}, 0, drawDone);
		end
	endtask

	initial begin
		lfsr = 32'he945;
		reset = 1'b1;
		init = 1'b0;
		regAction = 1'b0;
		applyAction = 1'b0;
		draw = 1'b0;
		{up, down, left, right} = 4'b0000;
		blocked = 1'b0;
		hit = 1'b0;
		modelStart();
		repeat (5) @(negedge clock);
		reset = 1'b0;

		testName = "reset";
		check("reset xPos", `LINK_START_X, xPos);
		check("reset yPos", `LINK_START_Y, yPos);
		check("reset hp", `LINK_START_HP, hp);
		check("reset pixelWrite", 0, pixelWrite);
		check("reset drawDone", 0, drawDone);

		testName = "commands";
		randomActivity(40, 1'b0);
		testName = "health";
		randomActivity(40, 1'b1);
		testName = "draw";
		repeat (4) begin
			randomActivity(6, 1'b1);
			drawSprite();
		end

		// a hit first, so init has invincibility to clear
		testName = "init";
		hit = 1'b1;
		clockCycle();
		hit = 1'b0;
		init = 1'b1;
		clockCycle();
		init = 1'b0;
		check("init xPos", `LINK_START_X, xPos);
		check("init yPos", `LINK_START_Y, yPos);
		check("init hp", `LINK_START_HP, hp);
		drawSprite();

		$display("Test completed successfully");
		$finish;
	end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+source
source/linkPkg.sv
source/linkMovement.sv
source/linkHealth.sv
source/spriteScanner.sv
source/linkCharacter.sv
sim/linkCharacterTb.sv

/* run.sh */
#!/bin/sh
# builds the testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal \
	--top-module linkCharacterTb \
	-f filelist.f \
	-Mdir build -o linkSim
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

./build/linkSim
status=$?
if [ $status -ne 0 ]; then
	echo "simulation ended with status $status"
	exit $status
fi

echo "simulation finished cleanly"
exit 0
